// ==== gfx_defines.svh ====
`ifndef GFX_DEFINES_SVH
`define GFX_DEFINES_SVH

// framebuffer geometry in pixels.
`define FB_WIDTH      12
`define FB_HEIGHT     8

// stored word and per-channel widths.
`define PIXEL_BITS    12
`define CHANNEL_BITS  4

// horizontal timing, in clocks.
`define H_VISIBLE     12
`define H_FRONT       2
`define H_SYNC        3
`define H_BACK        3

// vertical timing, in lines.
`define V_VISIBLE     8
`define V_FRONT       1
`define V_SYNC        2
`define V_BACK        1

`endif

// ==== gfx_pixel_pkg.sv ====
`include "gfx_defines.svh"

package gfx_pixel_pkg;

  typedef logic [`CHANNEL_BITS-1:0] channel_t;

  typedef struct packed {
    channel_t red;
    channel_t grn;
    channel_t blu;
  } rgb_t;

  // one stored word, raw for the memory, split for the colour logic.
  typedef union packed {
    logic [`PIXEL_BITS-1:0] raw;
    rgb_t                   rgb;
  } pixel_word_u;

  typedef logic [$clog2(`FB_WIDTH * `FB_HEIGHT)-1:0] fb_addr_t; // row-major.

endpackage

// ==== vga_timing_pkg.sv ====
`include "gfx_defines.svh"

package vga_timing_pkg;

  // beam position inside the framebuffer.
  typedef logic [$clog2(`FB_WIDTH)-1:0]  fb_x_t;
  typedef logic [$clog2(`FB_HEIGHT)-1:0] fb_y_t;

  // counters span the whole line and the whole frame.
  typedef logic [$clog2(`H_VISIBLE + `H_FRONT + `H_SYNC + `H_BACK)-1:0] h_count_t;
  typedef logic [$clog2(`V_VISIBLE + `V_FRONT + `V_SYNC + `V_BACK)-1:0] v_count_t;

endpackage

// ==== gfx_test_pattern.sv ====
`include "gfx_defines.svh"

module gfx_test_pattern (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       pready,
  output logic                       pvalid,
  output vga_timing_pkg::fb_x_t      x,
  output vga_timing_pkg::fb_y_t      y,
  output gfx_pixel_pkg::pixel_word_u color,
  output logic                       last,
  output logic                       done
);

  localparam vga_timing_pkg::fb_x_t MAX_X = vga_timing_pkg::fb_x_t'(`FB_WIDTH - 1);
  localparam vga_timing_pkg::fb_y_t MAX_Y = vga_timing_pkg::fb_y_t'(`FB_HEIGHT - 1);

  // bar edges at one and two thirds of the width.
  localparam vga_timing_pkg::fb_x_t GRN_START = vga_timing_pkg::fb_x_t'(`FB_WIDTH / 3);
  localparam vga_timing_pkg::fb_x_t BLU_START = vga_timing_pkg::fb_x_t'((`FB_WIDTH / 3) * 2);

  localparam gfx_pixel_pkg::channel_t CH_ON  = '1;
  localparam gfx_pixel_pkg::channel_t CH_OFF = '0;

  logic accepted;

  assign accepted = pvalid && pready;
  assign last     = (x == MAX_X) && (y == MAX_Y);

  // bar colour follows the current column.
  always_comb begin
    color.rgb.red = (x < GRN_START) ? CH_ON : CH_OFF;
    color.rgb.grn = (x >= GRN_START && x < BLU_START) ? CH_ON : CH_OFF;
    color.rgb.blu = (x >= BLU_START) ? CH_ON : CH_OFF;
  end

  // raster walk, one step per accepted pixel.
  always_ff @(posedge clk) begin
    if (reset) begin
      x <= '0;
      y <= '0;
    end else if (accepted && !done) begin
      if (x == MAX_X) begin
        x <= '0;
        y <= (y == MAX_Y) ? '0 : y + 1'b1;
      end else begin
        x <= x + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pvalid <= 1'b0;
    end else begin
      if (!done) begin
        pvalid <= 1'b1;
      end
      if (accepted) begin
        pvalid <= 1'b0; // one idle cycle per transfer.
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      done <= 1'b0;
    end else if (accepted && last) begin
      done <= 1'b1; // held until the next reset.
    end
  end

endmodule

// ==== gfx_framebuffer.sv ====
`include "gfx_defines.svh"

module gfx_framebuffer (
  input  logic                       clk,
  input  logic                       pvalid,
  input  vga_timing_pkg::fb_x_t      wr_x,
  input  vga_timing_pkg::fb_y_t      wr_y,
  input  gfx_pixel_pkg::pixel_word_u wr_pixel,
  output logic                       pready,
  input  logic                       visible,
  input  vga_timing_pkg::fb_x_t      rd_x,
  input  vga_timing_pkg::fb_y_t      rd_y,
  output gfx_pixel_pkg::pixel_word_u rd_pixel
);

  localparam int WORDS = `FB_WIDTH * `FB_HEIGHT;

  logic [`PIXEL_BITS-1:0] mem [WORDS];

  gfx_pixel_pkg::fb_addr_t wr_addr;
  gfx_pixel_pkg::fb_addr_t rd_addr;
  gfx_pixel_pkg::fb_addr_t addr;

  assign wr_addr = gfx_pixel_pkg::fb_addr_t'(wr_y * `FB_WIDTH + wr_x);
  assign rd_addr = gfx_pixel_pkg::fb_addr_t'(rd_y * `FB_WIDTH + rd_x);

  // the display owns the port while the beam is visible.
  assign pready = ~visible;
  assign addr   = visible ? rd_addr : wr_addr;

  // single port, write on the handshake edge.
  always_ff @(posedge clk) begin
    if (pvalid && pready) begin
      mem[addr] <= wr_pixel.raw;
    end
    rd_pixel.raw <= mem[addr]; // ready one cycle after the address.
  end

endmodule

// ==== vga_timing.sv ====
`include "gfx_defines.svh"

module vga_timing (
  input  logic                  clk,
  input  logic                  reset,
  output logic                  hsync,
  output logic                  vsync,
  output logic                  visible,
  output vga_timing_pkg::fb_x_t beam_x,
  output vga_timing_pkg::fb_y_t beam_y
);

  localparam int H_TOTAL = `H_VISIBLE + `H_FRONT + `H_SYNC + `H_BACK;
  localparam int V_TOTAL = `V_VISIBLE + `V_FRONT + `V_SYNC + `V_BACK;

  localparam vga_timing_pkg::h_count_t H_LAST       = vga_timing_pkg::h_count_t'(H_TOTAL - 1);
  localparam vga_timing_pkg::h_count_t H_VIS_END    = vga_timing_pkg::h_count_t'(`H_VISIBLE);
  localparam vga_timing_pkg::h_count_t H_SYNC_START =
    vga_timing_pkg::h_count_t'(`H_VISIBLE + `H_FRONT);
  localparam vga_timing_pkg::h_count_t H_SYNC_END   =
    vga_timing_pkg::h_count_t'(`H_VISIBLE + `H_FRONT + `H_SYNC);

  localparam vga_timing_pkg::v_count_t V_LAST       = vga_timing_pkg::v_count_t'(V_TOTAL - 1);
  localparam vga_timing_pkg::v_count_t V_VIS_END    = vga_timing_pkg::v_count_t'(`V_VISIBLE);
  localparam vga_timing_pkg::v_count_t V_SYNC_START =
    vga_timing_pkg::v_count_t'(`V_VISIBLE + `V_FRONT);
  localparam vga_timing_pkg::v_count_t V_SYNC_END   =
    vga_timing_pkg::v_count_t'(`V_VISIBLE + `V_FRONT + `V_SYNC);

  vga_timing_pkg::h_count_t h_count;
  vga_timing_pkg::v_count_t v_count;
  logic                     in_visible;

  assign in_visible = (h_count < H_VIS_END) && (v_count < V_VIS_END);

  // counters start at the first visible pixel.
  always_ff @(posedge clk) begin
    if (reset) begin
      h_count <= '0;
      v_count <= '0;
    end else if (h_count == H_LAST) begin
      h_count <= '0;
      v_count <= (v_count == V_LAST) ? '0 : v_count + 1'b1;
    end else begin
      h_count <= h_count + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      hsync   <= 1'b1;
      vsync   <= 1'b1;
      visible <= 1'b0;
      beam_x  <= '0;
      beam_y  <= '0;
    end else begin
      hsync   <= !(h_count >= H_SYNC_START && h_count < H_SYNC_END); // active low.
      vsync   <= !(v_count >= V_SYNC_START && v_count < V_SYNC_END);
      visible <= in_visible;
      beam_x  <= in_visible ? vga_timing_pkg::fb_x_t'(h_count) : '0;
      beam_y  <= in_visible ? vga_timing_pkg::fb_y_t'(v_count) : '0;
    end
  end

endmodule

// ==== vga_scanout.sv ====
module vga_scanout (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       hsync_in,
  input  logic                       vsync_in,
  input  logic                       visible,
  input  gfx_pixel_pkg::pixel_word_u rd_pixel,
  output logic                       hsync,
  output logic                       vsync,
  output gfx_pixel_pkg::channel_t    red,
  output gfx_pixel_pkg::channel_t    grn,
  output gfx_pixel_pkg::channel_t    blu
);

  logic visible_d;

  // one stage, matching the memory read latency.
  always_ff @(posedge clk) begin
    if (reset) begin
      hsync     <= 1'b1;
      vsync     <= 1'b1;
      visible_d <= 1'b0;
    end else begin
      hsync     <= hsync_in;
      vsync     <= vsync_in;
      visible_d <= visible;
    end
  end

  // blank outside the visible window.
  assign red = visible_d ? rd_pixel.rgb.red : '0;
  assign grn = visible_d ? rd_pixel.rgb.grn : '0;
  assign blu = visible_d ? rd_pixel.rgb.blu : '0;

endmodule

// ==== gfx_top.sv ====
module gfx_top (
  input  logic                    clk,
  input  logic                    reset,
  output logic                    hsync,
  output logic                    vsync,
  output gfx_pixel_pkg::channel_t red,
  output gfx_pixel_pkg::channel_t grn,
  output gfx_pixel_pkg::channel_t blu,
  output logic                    pattern_loaded
);

  logic                       pvalid;
  logic                       pready;
  vga_timing_pkg::fb_x_t      wr_x;
  vga_timing_pkg::fb_y_t      wr_y;
  gfx_pixel_pkg::pixel_word_u wr_pixel;

  logic                       hsync_raw;
  logic                       vsync_raw;
  logic                       visible;
  vga_timing_pkg::fb_x_t      beam_x;
  vga_timing_pkg::fb_y_t      beam_y;
  gfx_pixel_pkg::pixel_word_u rd_pixel;

  gfx_test_pattern pattern (
    .clk    (clk),
    .reset  (reset),
    .pready (pready),
    .pvalid (pvalid),
    .x      (wr_x),
    .y      (wr_y),
    .color  (wr_pixel),
    .last   (),
    .done   (pattern_loaded)
  );

  gfx_framebuffer fb (
    .clk      (clk),
    .pvalid   (pvalid),
    .wr_x     (wr_x),
    .wr_y     (wr_y),
    .wr_pixel (wr_pixel),
    .pready   (pready),
    .visible  (visible),
    .rd_x     (beam_x),
    .rd_y     (beam_y),
    .rd_pixel (rd_pixel)
  );

  vga_timing timing (
    .clk     (clk),
    .reset   (reset),
    .hsync   (hsync_raw),
    .vsync   (vsync_raw),
    .visible (visible),
    .beam_x  (beam_x),
    .beam_y  (beam_y)
  );

  vga_scanout scanout (
    .clk      (clk),
    .reset    (reset),
    .hsync_in (hsync_raw),
    .vsync_in (vsync_raw),
    .visible  (visible),
    .rd_pixel (rd_pixel),
    .hsync    (hsync),
    .vsync    (vsync),
    .red      (red),
    .grn      (grn),
    .blu      (blu)
  );

endmodule

// ==== gfx_top_tb.sv ====
`include "gfx_defines.svh"

module gfx_top_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 2;
  localparam int H_TOTAL      = `H_VISIBLE + `H_FRONT + `H_SYNC + `H_BACK;
  localparam int V_TOTAL      = `V_VISIBLE + `V_FRONT + `V_SYNC + `V_BACK;
  localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
  localparam int LOAD_FRAMES  = 2;
  localparam int RUN_FRAMES   = LOAD_FRAMES + 2; // load, frame start, one checked frame.
  localparam int WATCHDOG_CYCLES = (2 * RUN_FRAMES + 1) * FRAME_CYCLES + RESET_CYCLES + 1;

  localparam logic [`CHANNEL_BITS-1:0] FULL = '1;
  localparam logic [`CHANNEL_BITS-1:0] OFF  = '0;

  logic                    clk = 1'b0;
  logic                    reset;
  logic                    hsync;
  logic                    vsync;
  logic                    pattern_loaded;
  gfx_pixel_pkg::channel_t red;
  gfx_pixel_pkg::channel_t grn;
  gfx_pixel_pkg::channel_t blu;

  integer seed;
  int     errors       = 0;
  int     tests_run    = 0;
  int     tests_failed = 0;
  int     reset_line;

  // beam model, rebuilt from the sync pins.
  logic prev_hsync     = 1'b1;
  logic prev_vsync     = 1'b1;
  int   hfall_gap      = -1; // cycles since the last hsync fall.
  int   hlow_len       = -1;
  int   vfall_gap      = -1;
  int   vlow_len       = -1;
  int   phase          = -1; // cycles since the last hsync rise.
  int   line_idx       = -1; // hsync rises since the last vsync rise.
  int   col;
  int   row;
  int   frame_pixels   = 0;
  int   checked_frames = 0;
  logic check_bars     = 1'b0;

  gfx_top UUT (
    .clk            (clk),
    .reset          (reset),
    .hsync          (hsync),
    .vsync          (vsync),
    .red            (red),
    .grn            (grn),
    .blu            (blu),
    .pattern_loaded (pattern_loaded)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic log_error(input string msg);
    $display("ERROR at %0d ns: %s", $time, msg);
    errors++;
  endtask

  // three vertical bars split at thirds of the width.
  function automatic logic [3*`CHANNEL_BITS-1:0] bar_colour(input int column);
    if (column < `FB_WIDTH / 3) begin
      return {FULL, OFF, OFF};
    end else if (column < 2 * `FB_WIDTH / 3) begin
      return {OFF, FULL, OFF};
    end
    return {OFF, OFF, FULL};
  endfunction

  // pins are sampled on the falling edge, away from DUT updates.
  always @(negedge clk) begin
    if (reset) begin
      prev_hsync   = 1'b1;
      prev_vsync   = 1'b1;
      hfall_gap    = -1;
      hlow_len     = -1;
      vfall_gap    = -1;
      vlow_len     = -1;
      phase        = -1;
      line_idx     = -1;
      frame_pixels = 0;
      check_bars   = 1'b0;
    end else begin
      hfall_gap = (hfall_gap >= 0) ? hfall_gap + 1 : -1;
      vfall_gap = (vfall_gap >= 0) ? vfall_gap + 1 : -1;
      phase     = (phase >= 0) ? phase + 1 : -1;
      if (prev_hsync && !hsync) begin
        assert (hfall_gap < 0 || hfall_gap == H_TOTAL)
          else log_error($sformatf("hsync period %0d cycles, expected %0d", hfall_gap, H_TOTAL));
        hfall_gap = 0;
        hlow_len  = 0;
      end
      if (!hsync && hlow_len >= 0) hlow_len++;
      if (!prev_hsync && hsync) begin
        assert (hlow_len < 0 || hlow_len == `H_SYNC)
          else log_error($sformatf("hsync low %0d cycles, expected %0d", hlow_len, `H_SYNC));
        phase = 0;
        if (line_idx >= 0) line_idx++;
      end
      if (prev_vsync && !vsync) begin
        assert (vfall_gap < 0 || vfall_gap == FRAME_CYCLES)
          else log_error($sformatf("frame %0d cycles, expected %0d", vfall_gap, FRAME_CYCLES));
        vfall_gap = 0;
        vlow_len  = 0;
      end
      if (!vsync && vlow_len >= 0) vlow_len++;
      if (!prev_vsync && vsync) begin
        assert (vlow_len < 0 || vlow_len == `V_SYNC * H_TOTAL)
          else log_error($sformatf("vsync low %0d cycles, expected %0d", vlow_len,
                                   `V_SYNC * H_TOTAL));
        if (check_bars) begin
          assert (frame_pixels == `FB_WIDTH * `FB_HEIGHT)
            else log_error($sformatf("%0d bar pixels in frame, expected %0d", frame_pixels,
                                     `FB_WIDTH * `FB_HEIGHT));
          checked_frames++;
        end
        check_bars   = pattern_loaded; // only whole frames after the load.
        frame_pixels = 0;
        line_idx     = 0;
      end
      col = phase - `H_BACK;
      row = line_idx - `V_BACK;
      if (phase >= 0 && line_idx >= 0) begin
        if (col >= 0 && col < `H_VISIBLE && row >= 0 && row < `V_VISIBLE) begin
          if (check_bars) begin
            frame_pixels++;
            assert ({red, grn, blu} == bar_colour(col))
              else log_error($sformatf("pixel (%0d,%0d) colour %h, expected %h", col, row,
                                       {red, grn, blu}, bar_colour(col)));
          end
        end else begin
          assert (red == '0 && grn == '0 && blu == '0)
            else log_error($sformatf("colour %h in blanking", {red, grn, blu}));
        end
      end
      prev_hsync = hsync;
      prev_vsync = vsync;
    end
  end

  task automatic finish_test(input string name, input int start_errors);
    tests_run++;
    if (errors == start_errors) begin
      $display("test %0d %s: passed", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed, %0d errors", tests_run, name, errors - start_errors);
    end
  endtask

  // caller sits on a rising edge, or at time zero.
  task automatic hold_reset(input int cycles);
    reset <= 1'b1;
    repeat (cycles) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
  endtask

  task automatic check_idle(input string name);
    int start_errors;
    start_errors = errors;
    assert (hsync && vsync)
      else log_error($sformatf("syncs after reset hsync %b vsync %b", hsync, vsync));
    assert (red == '0 && grn == '0 && blu == '0)
      else log_error($sformatf("colour %h after reset", {red, grn, blu}));
    assert (!pattern_loaded) else log_error("pattern_loaded high after reset");
    finish_test(name, start_errors);
  endtask

  task automatic wait_for_load(input string name);
    int start_errors;
    int waited;
    start_errors = errors;
    waited = 0;
    while (!pattern_loaded && waited < LOAD_FRAMES * FRAME_CYCLES) begin
      @(negedge clk);
      waited++;
    end
    assert (pattern_loaded) else begin
      $display("pattern_loaded did not rise within %0d frames of reset", LOAD_FRAMES);
      errors++;
    end
    finish_test(name, start_errors);
  endtask

  task automatic scan_checked_frame(input string name);
    int start_errors;
    int target;
    start_errors = errors;
    target = checked_frames + 1;
    assert (pattern_loaded) else begin
      $display("no frame could be checked because the pattern never finished loading");
      errors++;
    end
    if (pattern_loaded) begin
      while (checked_frames < target) @(negedge clk);
    end
    finish_test(name, start_errors);
  endtask

  initial begin
    seed  = 58;
    reset = 1'b1;
    hold_reset(RESET_CYCLES);
    check_idle("idle outputs after power-up reset");
    wait_for_load("pattern load after power-up reset");
    scan_checked_frame("sync timing and bars after load");
    reset_line = ($random(seed) & 32'h7fff_ffff) % V_TOTAL;
    $display("reset pulse at line %0d of the next frame", reset_line);
    repeat (reset_line * H_TOTAL + 1) @(posedge clk);
    hold_reset(1);
    check_idle("idle outputs after mid-frame reset");
    wait_for_load("pattern reload after mid-frame reset");
    scan_checked_frame("sync timing and bars after reload");
    $display("summary: %0d tests, %0d passed, %0d failed, %0d errors", tests_run,
             tests_run - tests_failed, tests_failed, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout, the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("TEST FAIL");
    $finish;
  end

endmodule

// ==== gfx_pattern_fb.f ====
+incdir+.
gfx_pixel_pkg.sv
vga_timing_pkg.sv
gfx_test_pattern.sv
gfx_framebuffer.sv
vga_timing.sv
vga_scanout.sv
gfx_top.sv
gfx_top_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the gfx_top testbench with Verilator.

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f gfx_pattern_fb.f --top-module gfx_top_tb -Mdir obj_dir -o gfx_top_tb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/gfx_top_tb_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "TEST PASS" "$log"; then
  exit 0
fi
echo "pass message not found in $log"
exit 1
